//--- verilog/qpu_pkg.sv
package qpu_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  localparam int QUBIT_NUM  = 8;
  localparam int SREG_NUM   = 8;
  localparam int TIME_WIDTH = 24;
  localparam int WAIT_WIDTH = 20;
  localparam int GATE_WIDTH = 8;
  localparam int TIQ_DEPTH  = 4;
  localparam int EVQ_DEPTH  = 16;
  // holds up to EVQ_DEPTH events of one timepoint
  localparam int CNT_WIDTH  = 5;

  //////////////////////////////////////////////////////////////////////
  // instruction format
  //////////////////////////////////////////////////////////////////////

  // opcode lives in instr[31:28]
  typedef enum logic [3:0] {
    OP_NOP   = 4'd0,
    OP_SMIS  = 4'd1,
    OP_QWAIT = 4'd2,
    OP_QOP   = 4'd3
  } op_e;

  typedef logic [$clog2(SREG_NUM)-1:0] sreg_idx_t;
  typedef logic [QUBIT_NUM-1:0]        qubit_mask_t;
  typedef logic [TIME_WIDTH-1:0]       time_t;
  typedef logic [WAIT_WIDTH-1:0]       wait_t;
  typedef logic [GATE_WIDTH-1:0]       gate_t;
  typedef logic [CNT_WIDTH-1:0]        cnt_t;

  // immediate is shared by all opcodes:
  // SMIS mask in imm[7:0], QOP gate in imm[15:8], QWAIT wait in imm[19:0]
  typedef struct packed {
    op_e       op;
    sreg_idx_t sreg;
    logic [4:0] rsvd;
    wait_t     imm;
  } instr_t;

  //////////////////////////////////////////////////////////////////////
  // queue and output payloads
  //////////////////////////////////////////////////////////////////////

  // evq entry
  typedef struct packed {
    gate_t       gate;
    qubit_mask_t mask;
  } event_t;

  // tiq entry, one per closed timepoint with events
  typedef struct packed {
    time_t stamp;
    cnt_t  count;
  } timepoint_t;

  // released event as seen by the waveform side
  typedef struct packed {
    time_t       stamp;
    gate_t       gate;
    qubit_mask_t mask;
  } out_event_t;

endpackage

//--- verilog/qpu_queue.sv
module qpu_queue #(
  parameter type PAYLOAD_T = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     i_reset,
  input  logic     i_push,
  input  PAYLOAD_T i_data,
  input  logic     i_pop,
  output PAYLOAD_T o_data,
  output logic     o_full,
  output logic     o_empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  PAYLOAD_T         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign o_full  = (count == FULL_CNT);
  assign o_empty = (count == '0);
  assign o_data  = mem[rd_ptr];

  // guard against misuse at the edges
  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && !o_empty;

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      // simultaneous push and pop leaves occupancy alone
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

//--- verilog/qpu_issue.sv
module qpu_issue (
  input  logic                clk,
  input  logic                i_reset,
  input  logic                i_instr_valid,
  input  qpu_pkg::instr_t     i_instr,
  input  logic                i_tiq_full,
  input  logic                i_evq_full,
  output logic                o_instr_ready,
  output logic                o_tiq_push,
  output qpu_pkg::timepoint_t o_tiq_data,
  output logic                o_evq_push,
  output qpu_pkg::event_t     o_evq_data
);

  import qpu_pkg::*;

  logic        accept;
  logic        is_smis;
  logic        is_qop;
  logic        is_qwait;

  // architectural state
  qubit_mask_t mask_reg [SREG_NUM];
  time_t       prog_time;
  cnt_t        grp_cnt;

  qubit_mask_t sel_mask;
  gate_t       gate_code;
  wait_t       wait_time;

  //////////////////////////////////////////////////////////////////////
  // handshake and decode
  //////////////////////////////////////////////////////////////////////

  // stall on either queue full, keeps both pushes safe
  assign o_instr_ready = !i_tiq_full && !i_evq_full;
  assign accept        = i_instr_valid && o_instr_ready;

  always_comb
  begin
    is_smis  = 1'b0;
    is_qop   = 1'b0;
    is_qwait = 1'b0;
    case (i_instr.op)
      OP_SMIS:  is_smis  = 1'b1;
      OP_QOP:   is_qop   = 1'b1;
      OP_QWAIT: is_qwait = 1'b1;
      // NOP and unknown opcodes do nothing
      default:  is_smis  = 1'b0;
    endcase
  end

  assign sel_mask  = mask_reg[i_instr.sreg];
  assign gate_code = i_instr.imm[15:8];
  assign wait_time = i_instr.imm;

  //////////////////////////////////////////////////////////////////////
  // queue pushes
  //////////////////////////////////////////////////////////////////////

  // mask read before any SMIS in this cycle lands
  assign o_evq_push      = accept && is_qop;
  assign o_evq_data.gate = gate_code;
  assign o_evq_data.mask = sel_mask;

  // empty timepoints only move program time
  assign o_tiq_push       = accept && is_qwait && (grp_cnt != '0);
  assign o_tiq_data.stamp = prog_time;
  assign o_tiq_data.count = grp_cnt;

  //////////////////////////////////////////////////////////////////////
  // mask registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      for (int i = 0; i < SREG_NUM; i++)
      begin
        mask_reg[i] <= '0;
      end
    end
    else if (accept && is_smis)
    begin
      mask_reg[i_instr.sreg] <= i_instr.imm[QUBIT_NUM-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // program time and open group
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      prog_time <= '0;
      grp_cnt   <= '0;
    end
    else if (accept)
    begin
      if (is_qwait)
      begin
        // close the group, next one starts after the wait
        prog_time <= prog_time + time_t'(wait_time);
        grp_cnt   <= '0;
      end
      else if (is_qop)
      begin
        grp_cnt <= grp_cnt + 1'b1;
      end
    end
  end

endmodule

//--- verilog/qpu_timing_ctrl.sv
module qpu_timing_ctrl (
  input  logic                clk,
  input  logic                i_reset,
  input  qpu_pkg::timepoint_t i_tiq_data,
  input  logic                i_tiq_empty,
  input  qpu_pkg::event_t     i_evq_data,
  input  logic                i_evq_empty,
  output logic                o_tiq_pop,
  output logic                o_evq_pop,
  output logic                o_event_valid,
  output qpu_pkg::out_event_t o_event
);

  import qpu_pkg::*;

  // free running cycle timer, 0 on the first edge after reset
  time_t timer;

  // release state of the current timepoint
  logic  busy;
  time_t cur_time;
  cnt_t  remain;

  logic  tp_due;
  cnt_t  remain_sel;
  time_t stamp_sel;

  //////////////////////////////////////////////////////////////////////
  // pop control
  //////////////////////////////////////////////////////////////////////

  assign tp_due    = !busy && !i_tiq_empty && (timer >= i_tiq_data.stamp);
  assign o_tiq_pop = tp_due;

  // first event leaves together with its timepoint
  assign o_evq_pop = (tp_due || busy) && !i_evq_empty;

  assign remain_sel = busy ? remain : i_tiq_data.count;
  assign stamp_sel  = busy ? cur_time : i_tiq_data.stamp;

  always_ff @(posedge clk)
  begin
    if (i_reset)
      timer <= '0;
    else
      timer <= timer + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      busy   <= 1'b0;
      remain <= '0;
    end
    else
    begin
      if (tp_due)
      begin
        busy   <= 1'b1;
        remain <= i_tiq_data.count;
      end
      // last event of the group drops back to idle
      if (o_evq_pop)
      begin
        remain <= remain_sel - 1'b1;
        busy   <= (remain_sel != cnt_t'(1));
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (tp_due)
      cur_time <= i_tiq_data.stamp;
  end

  //////////////////////////////////////////////////////////////////////
  // event output, registered strobe
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (i_reset)
      o_event_valid <= 1'b0;
    else
      o_event_valid <= o_evq_pop;
  end

  always_ff @(posedge clk)
  begin
    if (o_evq_pop)
    begin
      o_event.stamp <= stamp_sel;
      o_event.gate  <= i_evq_data.gate;
      o_event.mask  <= i_evq_data.mask;
    end
  end

endmodule

//--- verilog/qpu_exu_top.sv
module qpu_exu_top (
  input  logic                clk,
  input  logic                i_reset,
  input  logic                i_instr_valid,
  input  qpu_pkg::instr_t     i_instr,
  output logic                o_instr_ready,
  output logic                o_event_valid,
  output qpu_pkg::out_event_t o_event
);

  import qpu_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // time queue wires
  //////////////////////////////////////////////////////////////////////

  logic       tiq_push;
  logic       tiq_pop;
  logic       tiq_full;
  logic       tiq_empty;
  timepoint_t tiq_wdata;
  timepoint_t tiq_rdata;

  //////////////////////////////////////////////////////////////////////
  // event queue wires
  //////////////////////////////////////////////////////////////////////

  logic       evq_push;
  logic       evq_pop;
  logic       evq_full;
  logic       evq_empty;
  event_t     evq_wdata;
  event_t     evq_rdata;

  qpu_issue issue_i (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_instr_valid (i_instr_valid),
    .i_instr       (i_instr),
    .i_tiq_full    (tiq_full),
    .i_evq_full    (evq_full),
    .o_instr_ready (o_instr_ready),
    .o_tiq_push    (tiq_push),
    .o_tiq_data    (tiq_wdata),
    .o_evq_push    (evq_push),
    .o_evq_data    (evq_wdata)
  );

  qpu_queue #(
    .PAYLOAD_T (timepoint_t),
    .DEPTH     (TIQ_DEPTH)
  ) tiq_i (
    .clk     (clk),
    .i_reset (i_reset),
    .i_push  (tiq_push),
    .i_data  (tiq_wdata),
    .i_pop   (tiq_pop),
    .o_data  (tiq_rdata),
    .o_full  (tiq_full),
    .o_empty (tiq_empty)
  );

  qpu_queue #(
    .PAYLOAD_T (event_t),
    .DEPTH     (EVQ_DEPTH)
  ) evq_i (
    .clk     (clk),
    .i_reset (i_reset),
    .i_push  (evq_push),
    .i_data  (evq_wdata),
    .i_pop   (evq_pop),
    .o_data  (evq_rdata),
    .o_full  (evq_full),
    .o_empty (evq_empty)
  );

  qpu_timing_ctrl timing_i (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_tiq_data    (tiq_rdata),
    .i_tiq_empty   (tiq_empty),
    .i_evq_data    (evq_rdata),
    .i_evq_empty   (evq_empty),
    .o_tiq_pop     (tiq_pop),
    .o_evq_pop     (evq_pop),
    .o_event_valid (o_event_valid),
    .o_event       (o_event)
  );

endmodule

//--- verif/qpu_ref_model.svh
`ifndef QPU_REF_MODEL_SVH
`define QPU_REF_MODEL_SVH

// one expected release, tagged with the timepoint it belongs to
typedef struct packed {
  int unsigned grp_id;
  out_event_t  ev;
} exp_event_t;

typedef instr_t     prog_list_t[$];
typedef exp_event_t exp_list_t[$];

// walks a program in order and lists the events in release order
function automatic exp_list_t expected_events(input prog_list_t prog);
  exp_list_t   done_q;
  exp_list_t   open_q;
  qubit_mask_t masks [SREG_NUM];
  time_t       now;
  int unsigned grp;
  exp_event_t  item;

  now = '0;
  grp = 0;
  for (int i = 0; i < SREG_NUM; i++)
    masks[i] = '0;
  foreach (prog[i])
  begin
    case (prog[i].op)
      OP_SMIS:
        masks[prog[i].sreg] = prog[i].imm[QUBIT_NUM-1:0];
      OP_QOP:
      begin
        // mask as it stands when the gate is issued
        item.grp_id   = grp;
        item.ev.stamp = now;
        item.ev.gate  = prog[i].imm[15:8];
        item.ev.mask  = masks[prog[i].sreg];
        open_q.push_back(item);
      end
      OP_QWAIT:
      begin
        foreach (open_q[j])
          done_q.push_back(open_q[j]);
        open_q.delete();
        now = now + time_t'(prog[i].imm);
        grp++;
      end
      default:
        grp = grp;
    endcase
  end
  // whatever is still open never leaves the slice
  return done_q;
endfunction

`endif

//--- verif/tb_qpu_exu.sv
module tb_qpu_exu;

  timeunit 1ns;
  timeprecision 100ps;

  import qpu_pkg::*;

  `include "qpu_ref_model.svh"

  localparam int RAND_LEN      = 59;
  localparam int DIR_GROUPS    = 4;
  localparam int DIR_GROUP_LEN = 5;

  logic        clk;
  logic        i_reset;
  logic        i_instr_valid;
  instr_t      i_instr;
  logic        o_instr_ready;
  logic        o_event_valid;
  out_event_t  o_event;

  prog_list_t  prog_q;
  exp_list_t   exp_q;
  exp_event_t  exp_item;
  integer      seed;
  int          err_cnt;
  int          cycle_cnt;
  int          cycle_limit;
  int          rx_cnt;
  int          last_cycle;
  int unsigned last_grp;
  int          dir_start;
  logic        dir_stall;

  qpu_exu_top dut_i (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_instr_valid (i_instr_valid),
    .i_instr       (i_instr),
    .o_instr_ready (o_instr_ready),
    .o_event_valid (o_event_valid),
    .o_event       (o_event)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      err_cnt++;
      $display("[ERROR] %0d ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic stop_run(input string reason);
    err_cnt++;
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // instruction words
  //////////////////////////////////////////////////////////////////////

  function automatic instr_t smis_word(input int sreg, input qubit_mask_t mask);
    instr_t ins;
    ins      = '0;
    ins.op   = OP_SMIS;
    ins.sreg = sreg_idx_t'(sreg);
    ins.imm[QUBIT_NUM-1:0] = mask;
    return ins;
  endfunction

  function automatic instr_t qop_word(input int sreg, input gate_t gate);
    instr_t ins;
    ins      = '0;
    ins.op   = OP_QOP;
    ins.sreg = sreg_idx_t'(sreg);
    ins.imm[15:8] = gate;
    return ins;
  endfunction

  function automatic instr_t qwait_word(input int wait_cycles);
    instr_t ins;
    ins     = '0;
    ins.op  = OP_QWAIT;
    ins.imm = wait_t'(wait_cycles);
    return ins;
  endfunction

  // opcode 0 or any unused code
  function automatic instr_t nop_word(input int code);
    instr_t ins;
    ins    = '0;
    ins.op = op_e'(4'(code));
    return ins;
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // programs
  //////////////////////////////////////////////////////////////////////

  task automatic build_program();
    int r;
    int open_cnt;
    open_cnt = 0;
    for (int i = 0; i < RAND_LEN; i++)
    begin
      r = rand_below(20);
      if (r < 5)
        prog_q.push_back(smis_word(rand_below(SREG_NUM), qubit_mask_t'(rand_below(256))));
      else if (r < 14 && open_cnt < 8)
      begin
        prog_q.push_back(qop_word(rand_below(SREG_NUM), gate_t'(rand_below(256))));
        open_cnt++;
      end
      else if (r < 18 || open_cnt == 8)
      begin
        prog_q.push_back(qwait_word(rand_below(41)));
        open_cnt = 0;
      end
      else
        prog_q.push_back(nop_word((rand_below(2) == 0) ? 0 : 4 + rand_below(12)));
    end
    prog_q.push_back(qwait_word(rand_below(41)));
    // long wait holds the next groups back until the evq fills
    dir_start = prog_q.size();
    prog_q.push_back(qwait_word(2000));
    for (int g = 0; g < DIR_GROUPS; g++)
    begin
      for (int k = 0; k < DIR_GROUP_LEN; k++)
        prog_q.push_back(qop_word(k, gate_t'(8'hA0 + g * DIR_GROUP_LEN + k)));
      prog_q.push_back(qwait_word(1));
    end
  endtask

  function automatic int run_limit(input prog_list_t prog);
    int total;
    total = 200 + 4 * prog.size();
    foreach (prog[i])
      if (prog[i].op == OP_QWAIT)
        total += int'(prog[i].imm);
    return total;
  endfunction

  // holds valid until the DUT takes the word
  task automatic send_instr(input instr_t ins, input logic directed);
    i_instr_valid <= 1'b1;
    i_instr       <= ins;
    @(posedge clk);
    while (!o_instr_ready)
    begin
      if (directed)
        dir_stall = 1'b1;
      @(posedge clk);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // cycle counter and compare process
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (!i_reset)
    begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit)
        stop_run("the run timed out before all expected events were released");
    end
  end

  always @(posedge clk)
  begin
    if (!i_reset && o_event_valid)
    begin
      if (exp_q.size() == 0)
        stop_run("the DUT released an event that the program does not contain");
      else
      begin
        exp_item = exp_q.pop_front();
        check_value(o_event.gate, exp_item.ev.gate, "gate code");
        check_value(o_event.mask, exp_item.ev.mask, "qubit mask");
        check_value(o_event.stamp, exp_item.ev.stamp, "timestamp");
        check_value(cycle_cnt >= exp_item.ev.stamp, 1'b1, "released before its timestamp");
        if (rx_cnt > 0 && exp_item.grp_id == last_grp)
          check_value(cycle_cnt, last_cycle + 1, "gap inside a timepoint");
        last_grp   = exp_item.grp_id;
        last_cycle = cycle_cnt;
        rx_cnt++;
      end
    end
  end

  initial
  begin
    seed          = 51835;
    err_cnt       = 0;
    cycle_cnt     = 0;
    rx_cnt        = 0;
    last_cycle    = 0;
    last_grp      = 0;
    dir_stall     = 1'b0;
    i_reset       = 1'b1;
    i_instr_valid = 1'b0;
    i_instr       = '0;
    build_program();
    exp_q       = expected_events(prog_q);
    cycle_limit = run_limit(prog_q);
    repeat (3) @(posedge clk);
    i_reset <= 1'b0;
    @(posedge clk);
    check_value(o_event_valid, 1'b0, "event strobe after reset");
    check_value(o_instr_ready, 1'b1, "ready after reset");
    foreach (prog_q[i])
      send_instr(prog_q[i], i >= dir_start);
    i_instr_valid <= 1'b0;
    while (exp_q.size() != 0)
      @(posedge clk);
    // catch anything extra after the last expected event
    repeat (20) @(posedge clk);
    check_value(dir_stall, 1'b1, "ready low during the long wait");
    if (err_cnt == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- files.f
+incdir+verif
verilog/qpu_pkg.sv
verilog/qpu_queue.sv
verilog/qpu_issue.sv
verilog/qpu_timing_ctrl.sv
verilog/qpu_exu_top.sv
verif/tb_qpu_exu.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -Wno-fatal --top-module tb_qpu_exu -f files.f -o tb_qpu_exu \
  && ./obj_dir/tb_qpu_exu > sim.log 2>&1 \
  || echo "build or simulation ended with an error"
[ -f sim.log ] && cat sim.log
grep -qF "*** TEST PASSED ***" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
